// ==== logic/sipo_pkg.sv ====
package sipo_pkg;

    // ########################################
    // Counter commands
    // ########################################

    typedef enum logic [1:0]
    {
        CNT_CLEAR = 2'b00,
        CNT_HOLD  = 2'b10,
        CNT_COUNT = 2'b11
    } counter_sel_t;

    localparam int COUNT_WIDTH = 20;  // Bit-time counter width

    // ########################################
    // Default frame and buffer setup
    // ########################################

    // The top level passes these down so every block sees the same frame shape
    localparam int PREAMBLE_BITS_DEFAULT = 3;
    localparam int DATA_BITS_DEFAULT     = 12;
    localparam int BUFFER_DEPTH_DEFAULT  = 4;
    localparam int INIT_CREDITS_DEFAULT  = 2;

endpackage

// ==== logic/sipo_controller.sv ====
`timescale 1ns/1ps

module sipo_controller
#(
    parameter int PREAMBLE_BITS = sipo_pkg::PREAMBLE_BITS_DEFAULT,
    parameter int DATA_BITS     = sipo_pkg::DATA_BITS_DEFAULT
)
(
    input  logic                             clk,
    input  logic                             reset_b,
    input  logic [sipo_pkg::COUNT_WIDTH-1:0] counter_value,
    input  logic                             space_available,
    output logic                             frame_req,
    output logic                             data_logging,
    output logic                             data_ready,
    output sipo_pkg::counter_sel_t           counter_sel
);

    typedef logic [sipo_pkg::COUNT_WIDTH-1:0] count_t;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_WAIT,
        S_PREAMBLE,
        S_LOGGING,
        S_READY
    } state_t;

    // Counter values seen on the last preamble bit and the last payload bit
    localparam count_t PREAMBLE_LAST = count_t'(PREAMBLE_BITS - 1);
    localparam count_t PAYLOAD_LAST  = count_t'(PREAMBLE_BITS + DATA_BITS - 1);

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    // ########################################
    // Next state and outputs
    // ########################################

    always_comb
    begin
        next_state   = state;
        frame_req    = 1'b0;
        data_logging = 1'b0;
        data_ready   = 1'b0;
        counter_sel  = sipo_pkg::CNT_CLEAR;

        case (state)
            S_IDLE:
            begin
                // A frame is only requested when the buffer can take its word
                if (reset_b && space_available)
                begin
                    frame_req  = 1'b1;
                    next_state = S_WAIT;
                end
            end
            S_WAIT:
            begin
                counter_sel = sipo_pkg::CNT_COUNT;  // Counter reads 0 here, bit 0 is on the line
                next_state  = (PREAMBLE_BITS > 1) ? S_PREAMBLE : S_LOGGING;
            end
            S_PREAMBLE:
            begin
                counter_sel = sipo_pkg::CNT_COUNT;
                if (counter_value == PREAMBLE_LAST)
                    next_state = S_LOGGING;
            end
            S_LOGGING:
            begin
                counter_sel  = sipo_pkg::CNT_COUNT;
                data_logging = 1'b1;
                if (counter_value == PAYLOAD_LAST)
                    next_state = S_READY;
            end
            S_READY:
            begin
                counter_sel = sipo_pkg::CNT_HOLD;
                data_ready  = 1'b1;  // Shift register is complete on this cycle
                next_state  = S_IDLE;
            end
            default:
            begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

// ==== logic/bit_counter.sv ====
`timescale 1ns/1ps

module bit_counter
(
    input  logic                             clk,
    input  logic                             reset_b,
    input  sipo_pkg::counter_sel_t           counter_sel,
    output logic [sipo_pkg::COUNT_WIDTH-1:0] counter_value
);

    // One step per bit time, steered by the controller
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            counter_value <= '0;
        end
        else
        begin
            case (counter_sel)
                sipo_pkg::CNT_CLEAR:
                    counter_value <= '0;
                sipo_pkg::CNT_COUNT:
                    counter_value <= counter_value + 1'b1;
                default:
                    counter_value <= counter_value;  // Hold, and the unused code
            endcase
        end
    end

endmodule

// ==== logic/sipo_shift_register.sv ====
`timescale 1ns/1ps

module sipo_shift_register
#(
    parameter int DATA_BITS = sipo_pkg::DATA_BITS_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 serial_in,
    input  logic                 data_logging,
    output logic [DATA_BITS-1:0] parallel_data
);

    // New bits enter at the bottom so the first logged bit ends up on top
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            parallel_data <= '0;
        end
        else if (data_logging)
        begin
            parallel_data <= {parallel_data[DATA_BITS-2:0], serial_in};
        end
    end

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
#(
    parameter int DATA_BITS    = sipo_pkg::DATA_BITS_DEFAULT,
    parameter int BUFFER_DEPTH = sipo_pkg::BUFFER_DEPTH_DEFAULT,
    parameter int INIT_CREDITS = sipo_pkg::INIT_CREDITS_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 data_ready,
    input  logic                 credit_return,
    input  logic [DATA_BITS-1:0] parallel_data,
    output logic                 space_available,
    output logic                 frame_valid,
    output logic [DATA_BITS-1:0] frame_data
);

    localparam int PTR_W    = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int FILL_W   = $clog2(BUFFER_DEPTH + 1);
    localparam int CREDIT_W = $clog2(INIT_CREDITS + 2);

    localparam logic [PTR_W-1:0]    PTR_LAST    = PTR_W'(BUFFER_DEPTH - 1);
    localparam logic [FILL_W-1:0]   FILL_FULL   = FILL_W'(BUFFER_DEPTH);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(INIT_CREDITS);

    logic [DATA_BITS-1:0] mem [BUFFER_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [FILL_W-1:0]    fill;
    logic [CREDIT_W-1:0]  credits;
    logic                 wr_en;
    logic                 send;

    assign space_available = (fill != FILL_FULL);
    assign wr_en           = data_ready && space_available;
    assign send            = (credits != '0) && (fill != '0);  // Oldest word goes out

    // ########################################
    // Pointers, fill level and credits
    // ########################################

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            credits     <= CREDIT_INIT;
            frame_valid <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (send)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;

            case ({wr_en, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase

            // A send and a returned credit in the same cycle cancel out
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            frame_valid <= send;
        end
    end

    // ########################################
    // Storage and output word
    // ########################################

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= parallel_data;
        if (send)
            frame_data <= mem[rd_ptr];
    end

endmodule

// ==== logic/sipo_logger_top.sv ====
`timescale 1ns/1ps

module sipo_logger_top
#(
    parameter int PREAMBLE_BITS = sipo_pkg::PREAMBLE_BITS_DEFAULT,
    parameter int DATA_BITS     = sipo_pkg::DATA_BITS_DEFAULT,
    parameter int BUFFER_DEPTH  = sipo_pkg::BUFFER_DEPTH_DEFAULT,
    parameter int INIT_CREDITS  = sipo_pkg::INIT_CREDITS_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 serial_in,
    input  logic                 credit_return,
    output logic                 frame_req,
    output logic                 frame_valid,
    output logic [DATA_BITS-1:0] frame_data
);

    logic [sipo_pkg::COUNT_WIDTH-1:0] counter_value;
    sipo_pkg::counter_sel_t           counter_sel;
    logic                             data_logging;
    logic                             data_ready;
    logic                             space_available;
    logic [DATA_BITS-1:0]             parallel_data;

    // Frame sequencing
    sipo_controller #(
        .PREAMBLE_BITS (PREAMBLE_BITS),
        .DATA_BITS     (DATA_BITS)
    ) u_controller (
        .clk             (clk),
        .reset_b         (reset_b),
        .counter_value   (counter_value),
        .space_available (space_available),
        .frame_req       (frame_req),
        .data_logging    (data_logging),
        .data_ready      (data_ready),
        .counter_sel     (counter_sel)
    );

    bit_counter u_bit_counter (
        .clk           (clk),
        .reset_b       (reset_b),
        .counter_sel   (counter_sel),
        .counter_value (counter_value)
    );

    sipo_shift_register #(
        .DATA_BITS (DATA_BITS)
    ) u_shift_register (
        .clk           (clk),
        .reset_b       (reset_b),
        .serial_in     (serial_in),
        .data_logging  (data_logging),
        .parallel_data (parallel_data)
    );

    // Finished words wait here for downstream credits
    frame_buffer #(
        .DATA_BITS    (DATA_BITS),
        .BUFFER_DEPTH (BUFFER_DEPTH),
        .INIT_CREDITS (INIT_CREDITS)
    ) u_frame_buffer (
        .clk             (clk),
        .reset_b         (reset_b),
        .data_ready      (data_ready),
        .credit_return   (credit_return),
        .parallel_data   (parallel_data),
        .space_available (space_available),
        .frame_valid     (frame_valid),
        .frame_data      (frame_data)
    );

endmodule

// ==== verification/sipo_logger_tb.sv ====
`timescale 1ns/1ps

module sipo_logger_tb;

    localparam int PREAMBLE_BITS = 3;
    localparam int DATA_BITS     = 12;
    localparam int BUFFER_DEPTH  = 4;
    localparam int INIT_CREDITS  = 2;
    localparam int FRAME_BITS    = PREAMBLE_BITS + DATA_BITS;

    logic                  clk;
    logic                  reset_b = 1'b0;
    logic                  serial_in = 1'b0;
    logic                  credit_return = 1'b0;
    logic                  frame_req;
    logic                  frame_valid;
    logic [DATA_BITS-1:0]  frame_data;

    integer                seed = 32'h1fe3;
    logic [31:0]           frame_rand;
    logic [31:0]           sink_rand;
    logic [FRAME_BITS-1:0] frame_bits;
    logic [DATA_BITS-1:0]  expected_q[$];
    int                    bit_idx = FRAME_BITS;
    int                    req_count = 0;
    int                    received = 0;
    int                    returned = 0;
    int                    manual_granted = 0;
    int                    manual_used = 0;
    int                    error_count = 0;
    int                    test_errors = 0;
    int                    pass_count = 0;
    int                    fail_count = 0;
    bit                    req_seen = 1'b0;
    bit                    credit_next = 1'b0;
    bit                    noise_bit = 1'b0;
    bit                    sink_auto = 1'b0;
    string                 current_test = "reset_state";

    sipo_logger_top #(
        .PREAMBLE_BITS (PREAMBLE_BITS),
        .DATA_BITS     (DATA_BITS),
        .BUFFER_DEPTH  (BUFFER_DEPTH),
        .INIT_CREDITS  (INIT_CREDITS)
    ) UUT (
        .clk           (clk),
        .reset_b       (reset_b),
        .serial_in     (serial_in),
        .credit_return (credit_return),
        .frame_req     (frame_req),
        .frame_valid   (frame_valid),
        .frame_data    (frame_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ########################################
    // Checks, waits and test bookkeeping
    // ########################################

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Frame in line order, preamble first and then the payload MSB first
    function automatic logic [FRAME_BITS-1:0] build_frame(
        input logic [PREAMBLE_BITS-1:0] preamble,
        input logic [DATA_BITS-1:0]     payload
    );
        logic [FRAME_BITS-1:0] bits;
        int                    k;
        bits[PREAMBLE_BITS-1:0] = preamble;
        for (k = 0; k < DATA_BITS; k++)
            bits[PREAMBLE_BITS + k] = payload[DATA_BITS - 1 - k];
        return bits;
    endfunction

    task automatic wait_for_count(input bit watch_requests, input int target, input int limit,
                                  input string what);
        int cycles;
        cycles = 0;
        while (((watch_requests ? req_count : received) < target) && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if ((watch_requests ? req_count : received) < target)
        begin
            error_count++;
            $display("Timeout in %s: %s not seen within %0d cycles", current_test, what, limit);
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_errors)
        begin
            pass_count++;
            $display("Test %s done with no errors", current_test);
        end
        else
        begin
            fail_count++;
            $display("Test %s done with %0d errors", current_test, error_count - test_errors);
        end
    endtask

    // ########################################
    // Source, sink and reference model
    // ########################################

    // Outputs are sampled mid-cycle, the model decides here what goes out on the next edge
    always @(negedge clk)
    begin
        req_seen = frame_req;
        if (req_seen)
        begin
            req_count++;
            frame_rand = $random(seed);
            frame_bits = build_frame(frame_rand[31 -: PREAMBLE_BITS], frame_rand[DATA_BITS-1:0]);
            expected_q.push_back(frame_rand[DATA_BITS-1:0]);
        end
        if (frame_valid)
        begin
            received++;
            if (expected_q.size() == 0)
            begin
                error_count++;
                $display("Word %0h arrived although no frame was requested for it", frame_data);
            end
            else
                check_value(current_test, 32'(expected_q.pop_front()), 32'(frame_data));
        end
        sink_rand   = $random(seed);
        noise_bit   = sink_rand[4];
        credit_next = (returned < received) &&
                      ((manual_used < manual_granted) || (sink_auto && sink_rand[1:0] == 2'b00));
        if (credit_next)
        begin
            returned++;
            if (manual_used < manual_granted)
                manual_used++;
        end
    end

    always @(posedge clk)
    begin
        if (req_seen)
        begin
            serial_in <= frame_bits[0];  // Bit 0 sits on the line while the counter reads 0
            bit_idx = 1;
        end
        else if (bit_idx < FRAME_BITS)
        begin
            serial_in <= frame_bits[bit_idx];
            bit_idx++;
        end
        else
            serial_in <= noise_bit;  // Idle line noise that must never reach a word
        credit_return <= credit_next;
    end

    // ########################################
    // Test sequence
    // ########################################

    initial
    begin
        start_test("reset_state");
        repeat (10)
        begin
            @(negedge clk);
            check_value("reset_state frame_req", 32'd0, 32'(frame_req));
            check_value("reset_state frame_valid", 32'd0, 32'(frame_valid));
        end
        @(posedge clk);
        reset_b <= 1'b1;
        @(negedge clk);
        // The buffer is empty after reset so a request goes out at once
        check_value("reset_state first request", 32'd1, 32'(frame_req));
        check_value("reset_state frame_valid", 32'd0, 32'(frame_valid));
        finish_test();

        start_test("credit_limit");
        wait_for_count(1'b0, INIT_CREDITS, 200, "words on the initial credits");
        wait_for_count(1'b1, INIT_CREDITS + BUFFER_DEPTH, 400, "requests that fill the buffer");
        repeat (60) @(posedge clk);
        check_value("credit_limit words", INIT_CREDITS, received);
        finish_test();

        start_test("back_pressure");
        check_value("back_pressure requests", INIT_CREDITS + BUFFER_DEPTH, req_count);
        finish_test();

        start_test("credit_return");
        manual_granted = 1;
        wait_for_count(1'b0, INIT_CREDITS + 1, 60, "word released by one returned credit");
        repeat (60) @(posedge clk);
        check_value("credit_return words", INIT_CREDITS + 1, received);
        finish_test();

        start_test("steady_run");
        sink_auto = 1'b1;
        wait_for_count(1'b0, INIT_CREDITS + 41, 2000, "forty words under random credits");
        // Words still owed are in the buffer or in the frame being shifted in
        check_value("steady_run outstanding", 32'd1,
                    32'(expected_q.size() <= BUFFER_DEPTH + 1));
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== sipo_logger.f ====
logic/sipo_pkg.sv
logic/sipo_controller.sv
logic/bit_counter.sv
logic/sipo_shift_register.sv
logic/frame_buffer.sv
logic/sipo_logger_top.sv
verification/sipo_logger_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the SIPO logger testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module sipo_logger_tb -f sipo_logger.f -o sipo_logger_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sipo_logger_sim)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "sim passed" <<< "$sim_output"; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
